// ==== Bender.yml ====
package:
  name: mrif_subsys

export_include_dirs:
  - hdl

sources:
  - hdl/mrif_pkg.sv
  - hdl/msi_req_decoder.sv
  - hdl/job_fifo.sv
  - hdl/mrif_handler.sv
  - hdl/mrif_subsys_top.sv
  - target: test
    files:
      - tests/mrif_subsys_assert.sv
      - tests/mrif_subsys_tb.sv

// ==== hdl/job_fifo.sv ====
// Show-ahead FIFO with a configurable payload type
`timescale 1ns/1ns

module job_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t           mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_push;
    logic               do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    // Requests outside the legal range are ignored
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // Head entry always visible
    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                // Wrap explicitly, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// ==== hdl/mrif_cfg.svh ====
// Address width, job FIFO depth and error cause macros for the MRIF subsystem
`ifndef MRIF_CFG_SVH
`define MRIF_CFG_SVH

// Physical address width
// MRIF base (47 bits) plus identity bits 10..6 plus 4 zero bits
`define MRIF_PLEN 56

// Job entries held between decoder and handler
`define MRIF_FIFO_DEPTH 4

// Width of the cause code on cause_o
`define MRIF_CAUSE_W 12

// Cause reported on any bus error during MRIF access
// MSI PT data corruption
`define MRIF_CAUSE_DATA_CORRUPT 270

`endif

// ==== hdl/mrif_handler.sv ====
// MRIF handler FSM for IP/IE read-modify-write and notice MSI writes
`timescale 1ns/1ns
`include "mrif_cfg.svh"

module mrif_handler (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  mrif_pkg::mrif_job_t        job_i,
    input  logic                       empty_i,
    output logic                       pop_o,
    output mrif_pkg::mem_req_t         mem_req_o,
    input  mrif_pkg::mem_rsp_t         mem_rsp_i,
    output logic                       error_o,
    output logic [`MRIF_CAUSE_W-1:0]   cause_o
);

    typedef enum logic [2:0] {
        IDLE,
        RD_REQ,
        FETCH,
        WR_IP,
        WR_NOTICE,
        ERROR
    } state_t;

    // Write steps, shared by IP write-back and notice
    typedef enum logic [1:0] {
        AW_REQ,
        W_DATA,
        B_RESP
    } wr_state_t;

    state_t              state_q, state_n;
    wr_state_t           wr_state_q, wr_state_n;
    mrif_pkg::mrif_job_t job_q, job_n;
    logic [63:0]         ip_q, ip_n;
    logic [63:0]         ie_q, ie_n;
    logic                wait_rlast_q, wait_rlast_n;
    logic                error_q;
    logic [63:0]         id_bit;
    logic                notice_sel;
    logic [`MRIF_PLEN-1:0] wr_addr;

    // Bit of this identity inside IP and IE
    assign id_bit = 64'd1 << job_q.bit_idx;

    // Notice page address, MSI sits at offset 0
    assign notice_sel = (state_q == WR_NOTICE);
    assign wr_addr    = notice_sel ? {job_q.notice_ppn, 12'b0} : job_q.pptr;

    assign error_o = error_q;
    assign cause_o = `MRIF_CAUSE_W'(`MRIF_CAUSE_DATA_CORRUPT);

    always_comb begin
        // Bus defaults
        mem_req_o.ar_valid = 1'b0;
        mem_req_o.ar_addr  = job_q.pptr;
        mem_req_o.ar_len   = 8'd1;             // IP then IE
        mem_req_o.aw_valid = 1'b0;
        mem_req_o.aw_addr  = wr_addr;
        mem_req_o.aw_size  = notice_sel ? 3'd2 : 3'd3;
        mem_req_o.w_valid  = 1'b0;
        mem_req_o.w_data   = notice_sel ? {53'b0, job_q.notice_nid} : (ip_q | id_bit);
        mem_req_o.w_strb   = notice_sel ? 8'h0f : 8'hff;
        mem_req_o.w_last   = 1'b1;             // Single-beat writes only
        mem_req_o.r_ready  = 1'b0;
        mem_req_o.b_ready  = 1'b0;
        pop_o              = 1'b0;

        state_n      = state_q;
        wr_state_n   = wr_state_q;
        job_n        = job_q;
        ip_n         = ip_q;
        ie_n         = ie_q;
        wait_rlast_n = wait_rlast_q;

        case (state_q)
            IDLE: begin
                // Take head of FIFO
                if (!empty_i) begin
                    pop_o        = 1'b1;
                    job_n        = job_i;
                    wait_rlast_n = 1'b0;
                    state_n      = RD_REQ;
                end
            end

            RD_REQ: begin
                mem_req_o.ar_valid = 1'b1;
                if (mem_rsp_i.ar_ready) begin
                    state_n = FETCH;
                end
            end

            FETCH: begin
                mem_req_o.r_ready = mem_rsp_i.r_valid;
                if (mem_rsp_i.r_valid) begin
                    if (mem_rsp_i.r_resp != mrif_pkg::RESP_OKAY) begin
                        // Drain the rest of the burst in ERROR
                        wait_rlast_n = ~mem_rsp_i.r_last;
                        state_n      = ERROR;
                    end else if (mem_rsp_i.r_last) begin
                        // Second beat is IE
                        ie_n       = mem_rsp_i.r_data;
                        wr_state_n = AW_REQ;
                        if (!(|(ip_q & id_bit))) begin
                            state_n = WR_IP;
                        end else if (|(mem_rsp_i.r_data & id_bit)) begin
                            // IP already pending, notice still due
                            state_n = WR_NOTICE;
                        end else begin
                            state_n = IDLE;
                        end
                    end else begin
                        // First beat is IP
                        ip_n = mem_rsp_i.r_data;
                    end
                end
            end

            WR_IP, WR_NOTICE: begin
                case (wr_state_q)
                    AW_REQ: begin
                        mem_req_o.aw_valid = 1'b1;
                        if (mem_rsp_i.aw_ready) begin
                            wr_state_n = W_DATA;
                        end
                    end
                    W_DATA: begin
                        mem_req_o.w_valid = 1'b1;
                        if (mem_rsp_i.w_ready) begin
                            wr_state_n = B_RESP;
                        end
                    end
                    B_RESP: begin
                        mem_req_o.b_ready = mem_rsp_i.b_valid;
                        if (mem_rsp_i.b_valid) begin
                            wr_state_n = AW_REQ;
                            if (mem_rsp_i.b_resp != mrif_pkg::RESP_OKAY) begin
                                state_n = ERROR;
                            end else if (!notice_sel && (|(ie_q & id_bit))) begin
                                // Interrupt enabled, send notice
                                state_n = WR_NOTICE;
                            end else begin
                                state_n = IDLE;
                            end
                        end
                    end
                    default: begin
                        wr_state_n = AW_REQ;
                        state_n    = IDLE;
                    end
                endcase
            end

            ERROR: begin
                if (wait_rlast_q) begin
                    mem_req_o.r_ready = mem_rsp_i.r_valid;
                    if (mem_rsp_i.r_valid && mem_rsp_i.r_last) begin
                        wait_rlast_n = 1'b0;
                        state_n      = IDLE;
                    end
                end else begin
                    state_n = IDLE;
                end
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            wr_state_q   <= AW_REQ;
            wait_rlast_q <= 1'b0;
            error_q      <= 1'b0;
        end else begin
            state_q      <= state_n;
            wr_state_q   <= wr_state_n;
            wait_rlast_q <= wait_rlast_n;
            // Pulse only on entry to ERROR
            error_q      <= (state_n == ERROR) && (state_q != ERROR);
        end
    end

    // Job and fetched data
    always_ff @(posedge clk_i) begin
        job_q <= job_n;
        ip_q  <= ip_n;
        ie_q  <= ie_n;
    end

endmodule

// ==== hdl/mrif_pkg.sv ====
// MSI request, MRIF job and memory port structs with bus response codes
`include "mrif_cfg.svh"

package mrif_pkg;

    // Bus response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Raw MSI with the MRIF cache data attached
    typedef struct packed {
        logic [31:0] int_id;
        logic [46:0] mrif_addr;
        logic [10:0] notice_nid;
        logic [43:0] notice_ppn;
    } msi_req_t;

    // Validated work item for the handler
    typedef struct packed {
        logic [`MRIF_PLEN-1:0] pptr;     // IP/IE pair address
        logic [5:0]            bit_idx;  // Bit inside IP and IE
        logic [10:0]           notice_nid;
        logic [43:0]           notice_ppn;
    } mrif_job_t;

    // Handler to memory
    typedef struct packed {
        logic                  ar_valid;
        logic [`MRIF_PLEN-1:0] ar_addr;
        logic [7:0]            ar_len;
        logic                  aw_valid;
        logic [`MRIF_PLEN-1:0] aw_addr;
        logic [2:0]            aw_size;
        logic                  w_valid;
        logic [63:0]           w_data;
        logic [7:0]            w_strb;
        logic                  w_last;
        logic                  r_ready;
        logic                  b_ready;
    } mem_req_t;

    // Memory to handler
    typedef struct packed {
        logic        ar_ready;
        logic        aw_ready;
        logic        w_ready;
        logic        r_valid;
        logic [63:0] r_data;
        logic [1:0]  r_resp;
        logic        r_last;
        logic        b_valid;
        logic [1:0]  b_resp;
    } mem_rsp_t;

endpackage

// ==== hdl/mrif_subsys_top.sv ====
// MRIF subsystem top with decoder, job FIFO and handler
`timescale 1ns/1ns
`include "mrif_cfg.svh"

module mrif_subsys_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       msi_valid_i,
    input  mrif_pkg::msi_req_t         msi_i,
    input  mrif_pkg::mem_rsp_t         mem_rsp_i,
    output mrif_pkg::mem_req_t         mem_req_o,
    output logic                       ignore_o,
    output logic                       drop_o,
    output logic                       error_o,
    output logic [`MRIF_CAUSE_W-1:0]   cause_o
);

    // Decoder to FIFO
    logic                fifo_push;
    mrif_pkg::mrif_job_t fifo_job;
    logic                fifo_full;
    logic                fifo_empty;
    // FIFO to handler
    logic                fifo_pop;
    mrif_pkg::mrif_job_t head_job;

    msi_req_decoder u_msi_req_decoder (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .msi_valid_i (msi_valid_i),
        .msi_i       (msi_i),
        .fifo_full_i (fifo_full),
        .push_o      (fifo_push),
        .job_o       (fifo_job),
        .ignore_o    (ignore_o),
        .drop_o      (drop_o)
    );

    job_fifo #(
        .payload_t (mrif_pkg::mrif_job_t),
        .DEPTH     (`MRIF_FIFO_DEPTH)
    ) u_job_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (fifo_push),
        .data_i  (fifo_job),
        .pop_i   (fifo_pop),
        .data_o  (head_job),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    mrif_handler u_mrif_handler (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .job_i     (head_job),
        .empty_i   (fifo_empty),
        .pop_o     (fifo_pop),
        .mem_req_o (mem_req_o),
        .mem_rsp_i (mem_rsp_i),
        .error_o   (error_o),
        .cause_o   (cause_o)
    );

endmodule

// ==== hdl/msi_req_decoder.sv ====
// MSI request decoder that checks the identity and builds MRIF jobs
`timescale 1ns/1ns

module msi_req_decoder (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 msi_valid_i,
    input  mrif_pkg::msi_req_t   msi_i,
    input  logic                 fifo_full_i,
    output logic                 push_o,
    output mrif_pkg::mrif_job_t  job_o,
    output logic                 ignore_o,
    output logic                 drop_o
);

    // Valid identity captured, waiting for the push decision
    logic                pend_q;
    logic                ignore_q;
    mrif_pkg::mrif_job_t job_q;
    logic                id_ok;

    // Identities above 2047 have no bit in the MRIF
    assign id_ok = ~(|msi_i.int_id[31:11]);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q   <= 1'b0;
            ignore_q <= 1'b0;
        end else begin
            pend_q   <= msi_valid_i & id_ok;
            ignore_q <= msi_valid_i & ~id_ok;
        end
    end

    // Job payload
    always_ff @(posedge clk_i) begin
        if (msi_valid_i) begin
            // DW pair offset taken from identity bits 10..6
            job_q.pptr       <= {msi_i.mrif_addr, msi_i.int_id[10:6], 4'b0000};
            job_q.bit_idx    <= msi_i.int_id[5:0];
            job_q.notice_nid <= msi_i.notice_nid;
            job_q.notice_ppn <= msi_i.notice_ppn;
        end
    end

    // Full checked in the push cycle so an in-flight push is counted
    assign push_o   = pend_q & ~fifo_full_i;
    assign drop_o   = pend_q & fifo_full_i;
    assign ignore_o = ignore_q;
    assign job_o    = job_q;

endmodule

// ==== mrif_subsys.f ====
+incdir+hdl
hdl/mrif_pkg.sv
hdl/msi_req_decoder.sv
hdl/job_fifo.sv
hdl/mrif_handler.sv
hdl/mrif_subsys_top.sv
tests/mrif_subsys_assert.sv
tests/mrif_subsys_tb.sv

// ==== tests/mrif_subsys_assert.sv ====
// Concurrent assertions on the handler memory port, FIFO push and error pulse
`timescale 1ns/1ns

module mrif_subsys_assert (
    input logic               clk_i,
    input logic               rst_ni,
    input mrif_pkg::mem_req_t mem_req_i,
    input mrif_pkg::mem_rsp_t mem_rsp_i,
    input logic               fifo_push_i,
    input logic               fifo_empty_i,
    input logic               error_i
);

    // Failed assertions so far
    int unsigned fail_cnt = 0;

    // AR request held until accepted
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i.ar_valid && !mem_rsp_i.ar_ready |=> mem_req_i.ar_valid)
        else begin
            $error("AR valid dropped before ready");
            fail_cnt++;
        end

    // AW request held until accepted
    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i.aw_valid && !mem_rsp_i.aw_ready |=> mem_req_i.aw_valid)
        else begin
            $error("AW valid dropped before ready");
            fail_cnt++;
        end

    // Pushed job is visible at the FIFO head in the next cycle
    push_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fifo_push_i |=> !fifo_empty_i)
        else begin
            $error("FIFO empty right after a push");
            fail_cnt++;
        end

    error_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        error_i |=> !error_i)
        else begin
            $error("error_o longer than one cycle");
            fail_cnt++;
        end

endmodule

// ==== tests/mrif_subsys_tb.sv ====
// Testbench for the MRIF subsystem with memory model, vector reader, checks and watchdog
`timescale 1ns/1ns
`include "mrif_cfg.svh"

module mrif_subsys_tb;

    localparam int VEC_WORDS   = 8;
    localparam int MAX_VEC     = 32;
    localparam int CYC_PER_VEC = 400;
    localparam int BURST_LEN   = `MRIF_FIFO_DEPTH + 3;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     msi_valid_i;
    mrif_pkg::msi_req_t       msi_i;
    mrif_pkg::mem_rsp_t       mem_rsp_i;
    mrif_pkg::mem_req_t       mem_req_o;
    logic                     ignore_o;
    logic                     drop_o;
    logic                     error_o;
    logic [`MRIF_CAUSE_W-1:0] cause_o;

    logic [63:0] vec_mem [VEC_WORDS*MAX_VEC];
    int          num_vec = 0;
    // Sparse memory keyed by doubleword address
    logic [63:0] mem [logic [55:0]];
    integer      seed = 32'h90e6_e2f2;
    logic [31:0] rnd;
    logic        stall;
    int          fault_sel;
    logic        wr_fault_used;
    // Event counters for the current vector
    int ar_cnt, rlast_cnt, b_cnt, err_cnt, ign_cnt, drop_cnt, push_cnt;
    // Observed and expected read requests
    logic [55:0] ar_addr_q [$];
    logic [55:0] exp_ar_q [$];
    // Observed and expected write beats
    logic [55:0] wr_addr_q [$];
    logic [63:0] wr_data_q [$];
    logic [7:0]  wr_strb_q [$];
    logic [2:0]  wr_size_q [$];
    logic [55:0] exp_addr_q [$];
    logic [63:0] exp_data_q [$];
    logic [7:0]  exp_strb_q [$];
    logic [2:0]  exp_size_q [$];
    // Memory model channel state
    logic        rd_active;
    logic [55:0] rd_addr;
    logic        rd_beat;
    logic        aw_have;
    logic [55:0] aw_addr;
    logic [2:0]  aw_size;
    logic        b_pend;
    logic        b_err;

    mrif_subsys_top u_mrif_subsys_top (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .msi_valid_i (msi_valid_i),
        .msi_i       (msi_i),
        .mem_rsp_i   (mem_rsp_i),
        .mem_req_o   (mem_req_o),
        .ignore_o    (ignore_o),
        .drop_o      (drop_o),
        .error_o     (error_o),
        .cause_o     (cause_o)
    );

    bind mrif_subsys_top mrif_subsys_assert u_mrif_subsys_assert (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_req_i    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .fifo_push_i  (fifo_push),
        .fifo_empty_i (fifo_empty),
        .error_i      (error_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [63:0] read_word(input logic [55:0] a);
        logic [55:0] k;
        k = {a[55:3], 3'b000};
        return mem.exists(k) ? mem[k] : 64'd0;
    endfunction

    // Byte-wise merge under strobe
    function automatic void store_word(input logic [55:0] a, input logic [63:0] d,
                                       input logic [7:0] s);
        logic [63:0] w;
        w = read_word(a);
        for (int i = 0; i < 8; i++) begin
            if (s[i]) w[8*i +: 8] = d[8*i +: 8];
        end
        mem[{a[55:3], 3'b000}] = w;
    endfunction

    // Bound assertion failures end the run
    always @(negedge clk_i) begin
        if (u_mrif_subsys_top.u_mrif_subsys_assert.fail_cnt != 0) begin
            $display("a bound assertion in mrif_subsys_assert failed");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // Memory model and monitors
    // Responses change on the falling edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (error_o) begin
                err_cnt++;
                check_eq("cause_o", cause_o, `MRIF_CAUSE_DATA_CORRUPT);
            end
            if (ignore_o) ign_cnt++;
            if (drop_o) drop_cnt++;
            if (u_mrif_subsys_top.fifo_push) push_cnt++;
            rnd = $random(seed);
            mem_rsp_i.ar_ready = rnd[0] & ~stall & ~rd_active;
            mem_rsp_i.aw_ready = rnd[1] & ~aw_have;
            mem_rsp_i.w_ready  = rnd[2] & aw_have & ~b_pend;
            mem_rsp_i.r_valid  = rnd[3] & rd_active;
            mem_rsp_i.r_data   = read_word(rd_addr + (rd_beat ? 56'd8 : 56'd0));
            // Read fault hits the IP beat
            mem_rsp_i.r_resp   = (fault_sel == 1 && !rd_beat) ? mrif_pkg::RESP_SLVERR
                                                              : mrif_pkg::RESP_OKAY;
            mem_rsp_i.r_last   = rd_beat;
            mem_rsp_i.b_valid  = rnd[4] & b_pend;
            mem_rsp_i.b_resp   = b_err ? mrif_pkg::RESP_SLVERR : mrif_pkg::RESP_OKAY;
            // Let the handler's combinational outputs settle
            #1;
            if (mem_req_o.ar_valid && mem_rsp_i.ar_ready) begin
                rd_active = 1'b1;
                rd_addr   = mem_req_o.ar_addr;
                rd_beat   = 1'b0;
                ar_cnt++;
                ar_addr_q.push_back(mem_req_o.ar_addr);
                // Two-beat burst for IP and IE
                check_eq("AR len", mem_req_o.ar_len, 64'd1);
            end
            if (mem_rsp_i.r_valid && mem_req_o.r_ready) begin
                if (rd_beat) begin
                    rd_active = 1'b0;
                    rlast_cnt++;
                end
                rd_beat = ~rd_beat;
            end
            if (mem_req_o.aw_valid && mem_rsp_i.aw_ready) begin
                aw_have = 1'b1;
                aw_addr = mem_req_o.aw_addr;
                aw_size = mem_req_o.aw_size;
            end
            if (mem_req_o.w_valid && mem_rsp_i.w_ready) begin
                check_eq("W last", mem_req_o.w_last, 64'd1);
                wr_addr_q.push_back(aw_addr);
                wr_data_q.push_back(mem_req_o.w_data);
                wr_strb_q.push_back(mem_req_o.w_strb);
                wr_size_q.push_back(aw_size);
                // Write fault on the first write of the job leaves memory unchanged
                b_err = (fault_sel == 2) && !wr_fault_used;
                if (b_err) wr_fault_used = 1'b1;
                else store_word(aw_addr, mem_req_o.w_data, mem_req_o.w_strb);
                b_pend = 1'b1;
            end
            if (mem_rsp_i.b_valid && mem_req_o.b_ready) begin
                b_pend  = 1'b0;
                aw_have = 1'b0;
                b_cnt++;
            end
        end
    end

    task automatic clear_counts();
        ar_cnt = 0;
        rlast_cnt = 0;
        b_cnt = 0;
        err_cnt = 0;
        ign_cnt = 0;
        drop_cnt = 0;
        push_cnt = 0;
        ar_addr_q.delete();
        exp_ar_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_strb_q.delete();
        wr_size_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_strb_q.delete();
        exp_size_q.delete();
    endtask

    task automatic expect_write(input logic [55:0] a, input logic [63:0] d,
                                input logic [7:0] s, input logic [2:0] sz);
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
        exp_strb_q.push_back(s);
        exp_size_q.push_back(sz);
    endtask

    task automatic drive_msi(input logic [63:0] id, input logic [63:0] base,
                             input logic [63:0] nid, input logic [63:0] ppn);
        @(negedge clk_i);
        msi_valid_i      = 1'b1;
        msi_i.int_id     = id[31:0];
        msi_i.mrif_addr  = base[46:0];
        msi_i.notice_nid = nid[10:0];
        msi_i.notice_ppn = ppn[43:0];
    endtask

    // Wait for the expected traffic and check that nothing else follows
    task automatic settle_and_check(input int jobs, input int errs, input int igns,
                                    input int drops);
        while (rlast_cnt < jobs || b_cnt < exp_addr_q.size() || err_cnt < errs
               || ign_cnt < igns || drop_cnt < drops) begin
            @(negedge clk_i);
        end
        repeat (8) @(negedge clk_i);
        check_eq("AR count", ar_cnt, jobs);
        check_eq("read burst count", rlast_cnt, jobs);
        check_eq("FIFO push count", push_cnt, jobs);
        check_eq("error pulse count", err_cnt, errs);
        check_eq("ignore pulse count", ign_cnt, igns);
        check_eq("drop pulse count", drop_cnt, drops);
        foreach (exp_ar_q[i]) begin
            check_eq($sformatf("read %0d address", i), ar_addr_q[i], exp_ar_q[i]);
        end
        check_eq("write count", wr_addr_q.size(), exp_addr_q.size());
        foreach (exp_addr_q[i]) begin
            check_eq($sformatf("write %0d address", i), wr_addr_q[i], exp_addr_q[i]);
            check_eq($sformatf("write %0d data", i), wr_data_q[i], exp_data_q[i]);
            check_eq($sformatf("write %0d strobe", i), wr_strb_q[i], exp_strb_q[i]);
            check_eq($sformatf("write %0d size", i), wr_size_q[i], exp_size_q[i]);
        end
    endtask

    task automatic run_vector(input int v);
        logic [63:0] kind, id, base, nid, ppn, ip, ie, fault, bitm, id_n;
        logic [55:0] pptr;
        logic        ip_written;
        int          jobs;
        kind  = vec_mem[v*VEC_WORDS];
        id    = vec_mem[v*VEC_WORDS+1];
        base  = vec_mem[v*VEC_WORDS+2];
        nid   = vec_mem[v*VEC_WORDS+3];
        ppn   = vec_mem[v*VEC_WORDS+4];
        ip    = vec_mem[v*VEC_WORDS+5];
        ie    = vec_mem[v*VEC_WORDS+6];
        fault = vec_mem[v*VEC_WORDS+7];
        clear_counts();
        fault_sel     = int'(fault);
        wr_fault_used = 1'b0;
        jobs          = (kind == 1) ? BURST_LEN : 1;
        for (int j = 0; j < jobs; j++) begin
            // Burst jobs step through the pair index in identity bits 10..6
            id_n       = id + 64'(j) * 64;
            pptr       = {base[46:0], id_n[10:6], 4'b0000};
            bitm       = 64'd1 << id_n[5:0];
            mem[pptr]  = ip;
            mem[pptr + 56'd8] = ie;
            if (|id_n[31:11] || j > `MRIF_FIFO_DEPTH) continue;
            exp_ar_q.push_back(pptr);
            if (fault != 1) begin
                if (!(ip & bitm)) expect_write(pptr, ip | bitm, 8'hff, 3'd3);
                if (fault != 2 && (ie & bitm)) begin
                    expect_write({ppn[43:0], 12'h000}, nid, 8'h0f, 3'd2);
                end
            end
        end
        stall = (kind == 1);
        for (int j = 0; j < jobs; j++) begin
            drive_msi(id + 64'(j) * 64, base, nid, ppn);
        end
        @(negedge clk_i);
        msi_valid_i = 1'b0;
        if (kind == 1) begin
            while (drop_cnt < 2) @(negedge clk_i);
            repeat (3) @(negedge clk_i);
            stall = 1'b0;
            settle_and_check(`MRIF_FIFO_DEPTH + 1, 0, 0, 2);
        end else if (|id[31:11]) begin
            settle_and_check(0, 0, 1, 0);
        end else begin
            settle_and_check(1, (fault != 0) ? 1 : 0, 0, 0);
        end
        // IP word in memory after the job
        for (int j = 0; j < jobs; j++) begin
            id_n = id + 64'(j) * 64;
            pptr = {base[46:0], id_n[10:6], 4'b0000};
            bitm = 64'd1 << id_n[5:0];
            ip_written = !(|id_n[31:11]) && fault == 0 && j <= `MRIF_FIFO_DEPTH;
            check_eq($sformatf("vector %0d job %0d IP word", v, j), read_word(pptr),
                     ip_written ? (ip | bitm) : ip);
        end
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        msi_valid_i = 1'b0;
        msi_i       = '0;
        mem_rsp_i   = '0;
        stall       = 1'b0;
        fault_sel   = 0;
        rd_active   = 1'b0;
        rd_addr     = '0;
        rd_beat     = 1'b0;
        aw_have     = 1'b0;
        aw_addr     = '0;
        aw_size     = '0;
        b_pend      = 1'b0;
        b_err       = 1'b0;
        clear_counts();
        $readmemh("tests/mrif_subsys_vectors.txt", vec_mem);
        if (vec_mem[0] === 'x) begin
            $display("vector file tests/mrif_subsys_vectors.txt could not be read");
            $display("SIMULATION FAILED");
            $fatal(1, "no vectors");
        end
        // Last line carries kind ff
        while (num_vec < MAX_VEC && vec_mem[num_vec*VEC_WORDS] !== 64'hff) begin
            num_vec++;
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int v = 0; v < num_vec; v++) begin
            run_vector(v);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog scaled by the vector count
    initial begin
        @(posedge rst_ni);
        #(num_vec * CYC_PER_VEC * 10 + 100);
        $display("timeout: the run did not finish within %0d cycles", num_vec * CYC_PER_VEC);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tests/mrif_subsys_vectors.txt ====
// kind int_id mrif_base notice_nid notice_ppn ip ie fault (hex, one MSI per line)
// kind 0 single MSI, 1 stalled burst, ff end; fault 1 read error, 2 first write error
0 45 1000 123 80000 0 0 0
0 7c1 1000 2a 80001 f0 2 0
0 3 1001 7ff 80002 8 8 0
0 2 1002 55 80003 4 0 0
0 800 1003 66 80004 0 ffffffffffffffff 0
0 10 1004 77 80005 0 1 1
0 11 1005 88 80006 0 ffffffffffffffff 2
0 12 1006 99 80007 0 40000 0
1 40 2000 aa 80008 0 0 0
0 5 2001 bb 80009 0 ffffffffffffffff 0
ff 0 0 0 0 0 0 0
